//--- hdl/la_acquire.sv
////////////////////////////////////////
// acquire controller
// arm, trigger, post-trigger count,
// marks the last output sample
////////////////////////////////////////

`timescale 1ns/1ps

`include "la_defs.svh"

module la_acquire (
  input  logic                  bus,
  input  logic                  rst_n,
  input  logic                  ctl_rst,   // back to idle
  input  logic                  ctl_acq,   // start a run
  input  logic                  ctl_trg,   // sw / ext trigger pulse
  input  la_stream_pkg::cnt_t   cfg_dly,   // samples after the trigger sample
  output la_stream_pkg::cnt_t   sts_dly,   // samples still to send
  output logic                  sts_acq,
  output logic                  sts_trg,
  // from the buffer
  input  la_stream_pkg::fsmp_t  sti_dat,
  input  logic                  sti_vld,
  output logic                  sti_rdy,
  // output stream
  output la_stream_pkg::dat_t   sto_dat,
  output logic                  sto_vld,
  input  logic                  sto_rdy,
  output logic                  sto_lst
);

  la_regs_pkg::acq_state_t state;

  logic run;      // forwarding states
  logic flag;     // edge trigger bit of the head sample
  logic room;     // output register free this cycle
  logic load;     // head sample moves to the output register
  logic trg_smp;  // loaded sample is the trigger sample
  logic lst_nxt;  // loaded sample ends the run

  assign run  = (state == la_regs_pkg::ST_ARM) || (state == la_regs_pkg::ST_POST);
  assign flag = sti_dat[`LA_DAT_W];
  assign room = ~sto_vld | sto_rdy;

  // in post, stop pulling once the last sample is loaded
  // outside a run, pop and drop at full rate
  assign sti_rdy = run ? (room & ((state == la_regs_pkg::ST_ARM) || (sts_dly != '0)))
                       : 1'b1;
  assign load    = run & sti_vld & sti_rdy;

  // a pending sw/ext trigger (sts_trg while armed) claims the next sample
  assign trg_smp = (state == la_regs_pkg::ST_ARM) & (flag | ctl_trg | sts_trg);
  assign lst_nxt = trg_smp ? (cfg_dly == '0)
                           : ((state == la_regs_pkg::ST_POST) && (sts_dly == 32'd1));

  assign sts_acq = run;

  ////////////////////////////////////////
  // state machine
  ////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n || ctl_rst) begin
      state   <= la_regs_pkg::ST_IDLE;
      sts_trg <= 1'b0;
      sts_dly <= '0;
    end else begin
      case (state)
        la_regs_pkg::ST_IDLE,
        la_regs_pkg::ST_DONE: begin
          if (ctl_acq) begin
            state   <= la_regs_pkg::ST_ARM;
            sts_trg <= 1'b0;  // fresh run
          end
        end
        la_regs_pkg::ST_ARM: begin
          if (ctl_trg || (load && flag)) sts_trg <= 1'b1;
          if (load && trg_smp) begin
            sts_dly <= cfg_dly;  // count what follows this sample
            state   <= la_regs_pkg::ST_POST;
          end
        end
        la_regs_pkg::ST_POST: begin
          if (load) sts_dly <= sts_dly - 1'b1;
          // leave on the transfer of the marked sample
          if (sto_vld && sto_rdy && sto_lst) state <= la_regs_pkg::ST_DONE;
        end
        default: state <= la_regs_pkg::ST_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n || ctl_rst) begin
      sto_vld <= 1'b0;
      sto_lst <= 1'b0;
    end else if (load) begin
      sto_vld <= 1'b1;
      sto_lst <= lst_nxt;
    end else if (sto_rdy) begin
      sto_vld <= 1'b0;  // drained
      sto_lst <= 1'b0;
    end
  end

  always_ff @(posedge bus) begin
    if (load) sto_dat <= sti_dat[`LA_DAT_W-1:0];  // flag stripped
  end

endmodule

//--- hdl/la_decimator.sv
////////////////////////////////////////
// stream decimator
// keeps one of every cfg_dec+1 samples
////////////////////////////////////////

`timescale 1ns/1ps

`include "la_defs.svh"

module la_decimator (
  input  logic                  bus,
  input  logic                  rst_n,
  input  logic                  ctl_rst,   // sync clear
  input  la_stream_pkg::dec_t   cfg_dec,
  // input stream
  input  la_stream_pkg::dat_t   sti_dat,
  input  logic                  sti_vld,
  output logic                  sti_rdy,
  // decimated stream
  output la_stream_pkg::dat_t   sto_dat,
  output logic                  sto_vld,
  input  logic                  sto_rdy
);

  la_stream_pkg::dec_t cnt;  // accepted samples since last kept one
  logic                acc;  // input transfer
  logic                keep; // this transfer goes to the output

  // dropped samples also wait, keeps the input in step with the buffer
  assign sti_rdy = ~sto_vld | sto_rdy;
  assign acc     = sti_vld & sti_rdy;
  assign keep    = acc & (cnt == '0);

  // wrap counter, >= guards a shrinking cfg_dec
  always_ff @(posedge bus) begin
    if (!rst_n || ctl_rst) begin
      cnt <= '0;
    end else if (acc) begin
      if (cnt >= cfg_dec) cnt <= '0;
      else                cnt <= cnt + `LA_DEC_W'(1);
    end
  end

  // output valid
  always_ff @(posedge bus) begin
    if (!rst_n || ctl_rst) begin
      sto_vld <= 1'b0;
    end else if (keep) begin
      sto_vld <= 1'b1;
    end else if (sto_rdy) begin
      sto_vld <= 1'b0;  // taken downstream
    end
  end

  // output data, only loads on a kept sample
  always_ff @(posedge bus) begin
    if (keep) sto_dat <= sti_dat;
  end

endmodule

//--- hdl/la_defs.svh
////////////////////////////////////////
// logic analyzer widths and sizes
// shared by all RTL blocks
////////////////////////////////////////

`ifndef LA_DEFS_SVH
`define LA_DEFS_SVH

// stream sample
`define LA_DAT_W 8

// decimation counter
`define LA_DEC_W 17

// external trigger lines and their select
`define LA_TRG_W 4
`define LA_TRG_SEL_W 2

// post-trigger delay counter
`define LA_CNT_W 32

// decoded register address
`define LA_ADR_W 6

// sample buffer entries
`define LA_FIFO_DEPTH 8

`endif

//--- hdl/la_fifo.sv
////////////////////////////////////////
// flagged sample buffer
// sync FIFO, trigger -> acquire
////////////////////////////////////////

`timescale 1ns/1ps

`include "la_defs.svh"

module la_fifo (
  input  logic                  bus,
  input  logic                  rst_n,
  input  logic                  ctl_rst,
  // push side
  input  la_stream_pkg::fsmp_t  push_dat,
  input  logic                  push_vld,
  output logic                  push_rdy,  // not full
  // pop side
  output la_stream_pkg::fsmp_t  pop_dat,
  output logic                  pop_vld,   // not empty
  input  logic                  pop_rdy
);

  localparam int unsigned DEPTH = `LA_FIFO_DEPTH;
  localparam int unsigned AW    = $clog2(DEPTH);
  localparam int unsigned CW    = $clog2(DEPTH + 1);

  la_stream_pkg::fsmp_t mem [DEPTH];  // storage

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] fill;   // entries held
  logic          push;
  logic          pop;

  assign push_rdy = fill != CW'(DEPTH);
  assign pop_vld  = fill != '0;
  assign push     = push_vld & push_rdy;
  assign pop      = pop_vld & pop_rdy;

  // head entry, readable the cycle after its push
  assign pop_dat = mem[rd_ptr];

  always_ff @(posedge bus) begin
    if (push) mem[wr_ptr] <= push_dat;
  end

  ////////////////////////////////////////
  // pointers and fill count
  ////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n || ctl_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) begin
        if (wr_ptr == AW'(DEPTH - 1)) wr_ptr <= '0;  // wrap
        else                          wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        if (rd_ptr == AW'(DEPTH - 1)) rd_ptr <= '0;
        else                          rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves fill alone
      if (push && !pop)      fill <= fill + 1'b1;
      else if (pop && !push) fill <= fill - 1'b1;
    end
  end

endmodule

//--- hdl/la_regs_pkg.sv
////////////////////////////////////////
// register bus types and map
// plus the acquire FSM states
////////////////////////////////////////

package la_regs_pkg;

  typedef logic [5:0]  adr_t;   // decoded address
  typedef logic [31:0] word_t;  // bus data

  ////////////////////////////////////////
  // register offsets
  ////////////////////////////////////////

  localparam word_t REG_CTL     = 32'h00;  // clear / sw trigger / start
  localparam word_t REG_SEL     = 32'h08;  // ext trigger select
  localparam word_t REG_DLY     = 32'h0c;  // post-trigger samples
  localparam word_t REG_MSK_CUR = 32'h10;
  localparam word_t REG_MSK_OLD = 32'h14;
  localparam word_t REG_VAL_CUR = 32'h18;
  localparam word_t REG_VAL_OLD = 32'h1c;
  localparam word_t REG_DEC     = 32'h28;  // keep 1 of dec+1
  localparam word_t REG_STS_DLY = 32'h2c;  // delay counter, read only

  // acquire controller states
  typedef enum logic [1:0] {
    ST_IDLE,  // discarding
    ST_ARM,   // forwarding, waiting for trigger
    ST_POST,  // forwarding post-trigger samples
    ST_DONE   // run finished, discarding
  } acq_state_t;

endpackage

//--- hdl/la_stream_pkg.sv
////////////////////////////////////////
// stream side types
// samples, flagged samples, counters
////////////////////////////////////////

package la_stream_pkg;

  // one sample off the input stream
  typedef logic [7:0] dat_t;

  // sample with trigger flag on top, FIFO entry
  typedef logic [8:0] fsmp_t;

  // decimation factor
  typedef logic [16:0] dec_t;

  // post-trigger delay
  typedef logic [31:0] cnt_t;

endpackage

//--- hdl/la_top.sv
////////////////////////////////////////
// logic analyzer top
// register bank, trigger select and
// decimator -> FIFO -> acquire path
////////////////////////////////////////

`timescale 1ns/1ps

`include "la_defs.svh"

module la_top (
  input  logic                      bus,        // clock
  input  logic                      rst_n,
  // input stream
  input  la_stream_pkg::dat_t       sti_dat,
  input  logic                      sti_vld,
  output logic                      sti_rdy,
  // output stream
  output la_stream_pkg::dat_t       sto_dat,
  output logic                      sto_vld,
  input  logic                      sto_rdy,
  output logic                      sto_lst,
  // triggers
  input  logic [`LA_TRG_W-1:0]      trg_ext,
  output logic                      trg_swo,    // sw trigger strobe
  output logic                      trg_out,    // edge trigger hit
  // register bus
  input  la_regs_pkg::word_t        bus_addr,
  input  la_regs_pkg::word_t        bus_wdata,
  input  logic                      bus_wen,
  input  logic                      bus_ren,
  output la_regs_pkg::word_t        bus_rdata,
  output logic                      bus_ack,
  output logic                      bus_err
);

  la_regs_pkg::adr_t         adr;
  logic                      ctl_wen;   // write to REG_CTL
  logic                      ctl_rst;
  logic                      ctl_acq;
  logic                      ctl_trg;
  // configuration
  logic [`LA_TRG_SEL_W-1:0]  cfg_sel;
  la_stream_pkg::cnt_t       cfg_dly;
  la_stream_pkg::dat_t       cfg_msk_cur;
  la_stream_pkg::dat_t       cfg_msk_old;
  la_stream_pkg::dat_t       cfg_val_cur;
  la_stream_pkg::dat_t       cfg_val_old;
  la_stream_pkg::dec_t       cfg_dec;
  // status
  la_stream_pkg::cnt_t       sts_dly;
  logic                      sts_acq;
  logic                      sts_trg;
  // decimated stream
  la_stream_pkg::dat_t       dec_dat;
  logic                      dec_vld;
  logic                      dec_rdy;
  logic                      trg_flag;
  // buffer output
  la_stream_pkg::fsmp_t      fifo_dat;
  logic                      fifo_vld;
  logic                      fifo_rdy;

  ////////////////////////////////////////
  // register bank
  ////////////////////////////////////////

  assign adr     = bus_addr[`LA_ADR_W-1:0];
  assign bus_err = 1'b0;  // no error responses

  always_ff @(posedge bus) begin
    if (!rst_n) bus_ack <= 1'b0;
    else        bus_ack <= bus_wen | bus_ren;  // one cycle later
  end

  // single-cycle strobes in the write cycle
  assign ctl_wen = bus_wen & (adr == la_regs_pkg::adr_t'(la_regs_pkg::REG_CTL));
  assign ctl_rst = ctl_wen & bus_wdata[0];
  assign trg_swo = ctl_wen & bus_wdata[1];
  assign ctl_acq = ctl_wen & bus_wdata[2];

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      cfg_sel     <= '0;
      cfg_dly     <= '0;
      cfg_msk_cur <= '0;
      cfg_msk_old <= '0;
      cfg_val_cur <= '0;
      cfg_val_old <= '0;
      cfg_dec     <= '0;
    end else if (bus_wen) begin
      case (adr)
        la_regs_pkg::adr_t'(la_regs_pkg::REG_SEL):     cfg_sel <= bus_wdata[`LA_TRG_SEL_W-1:0];
        la_regs_pkg::adr_t'(la_regs_pkg::REG_DLY):     cfg_dly <= bus_wdata[`LA_CNT_W-1:0];
        la_regs_pkg::adr_t'(la_regs_pkg::REG_MSK_CUR): cfg_msk_cur <= bus_wdata[`LA_DAT_W-1:0];
        la_regs_pkg::adr_t'(la_regs_pkg::REG_MSK_OLD): cfg_msk_old <= bus_wdata[`LA_DAT_W-1:0];
        la_regs_pkg::adr_t'(la_regs_pkg::REG_VAL_CUR): cfg_val_cur <= bus_wdata[`LA_DAT_W-1:0];
        la_regs_pkg::adr_t'(la_regs_pkg::REG_VAL_OLD): cfg_val_old <= bus_wdata[`LA_DAT_W-1:0];
        la_regs_pkg::adr_t'(la_regs_pkg::REG_DEC):     cfg_dec <= bus_wdata[`LA_DEC_W-1:0];
        default: ;  // ctl strobes and read-only
      endcase
    end
  end

  // registered read mux, lines up with bus_ack
  always_ff @(posedge bus) begin
    case (adr)
      la_regs_pkg::adr_t'(la_regs_pkg::REG_CTL):
        bus_rdata <= la_regs_pkg::word_t'({sts_acq, sts_trg, 1'b0});
      la_regs_pkg::adr_t'(la_regs_pkg::REG_SEL):     bus_rdata <= la_regs_pkg::word_t'(cfg_sel);
      la_regs_pkg::adr_t'(la_regs_pkg::REG_DLY):     bus_rdata <= cfg_dly;
      la_regs_pkg::adr_t'(la_regs_pkg::REG_MSK_CUR): bus_rdata <= la_regs_pkg::word_t'(cfg_msk_cur);
      la_regs_pkg::adr_t'(la_regs_pkg::REG_MSK_OLD): bus_rdata <= la_regs_pkg::word_t'(cfg_msk_old);
      la_regs_pkg::adr_t'(la_regs_pkg::REG_VAL_CUR): bus_rdata <= la_regs_pkg::word_t'(cfg_val_cur);
      la_regs_pkg::adr_t'(la_regs_pkg::REG_VAL_OLD): bus_rdata <= la_regs_pkg::word_t'(cfg_val_old);
      la_regs_pkg::adr_t'(la_regs_pkg::REG_DEC):     bus_rdata <= la_regs_pkg::word_t'(cfg_dec);
      la_regs_pkg::adr_t'(la_regs_pkg::REG_STS_DLY): bus_rdata <= sts_dly;
      default:                                       bus_rdata <= '0;  // unmapped
    endcase
  end

  ////////////////////////////////////////
  // trigger sources
  ////////////////////////////////////////

  assign ctl_trg = trg_ext[cfg_sel] | trg_swo;
  assign trg_out = trg_flag & dec_vld & dec_rdy;  // only on a real transfer

  ////////////////////////////////////////
  // sample path
  ////////////////////////////////////////

  la_decimator u_dec (
    .bus     (bus),
    .rst_n   (rst_n),
    .ctl_rst (ctl_rst),
    .cfg_dec (cfg_dec),
    .sti_dat (sti_dat),
    .sti_vld (sti_vld),
    .sti_rdy (sti_rdy),
    .sto_dat (dec_dat),
    .sto_vld (dec_vld),
    .sto_rdy (dec_rdy)
  );

  la_trigger u_trg (
    .bus         (bus),
    .rst_n       (rst_n),
    .ctl_rst     (ctl_rst),
    .cfg_msk_cur (cfg_msk_cur),
    .cfg_msk_old (cfg_msk_old),
    .cfg_val_cur (cfg_val_cur),
    .cfg_val_old (cfg_val_old),
    .str_dat     (dec_dat),
    .str_vld     (dec_vld),
    .str_rdy     (dec_rdy),
    .trg_flag    (trg_flag)
  );

  la_fifo u_fifo (
    .bus      (bus),
    .rst_n    (rst_n),
    .ctl_rst  (ctl_rst),
    .push_dat ({trg_flag, dec_dat}),  // flag rides on top
    .push_vld (dec_vld),
    .push_rdy (dec_rdy),
    .pop_dat  (fifo_dat),
    .pop_vld  (fifo_vld),
    .pop_rdy  (fifo_rdy)
  );

  la_acquire u_acq (
    .bus     (bus),
    .rst_n   (rst_n),
    .ctl_rst (ctl_rst),
    .ctl_acq (ctl_acq),
    .ctl_trg (ctl_trg),
    .cfg_dly (cfg_dly),
    .sts_dly (sts_dly),
    .sts_acq (sts_acq),
    .sts_trg (sts_trg),
    .sti_dat (fifo_dat),
    .sti_vld (fifo_vld),
    .sti_rdy (fifo_rdy),
    .sto_dat (sto_dat),
    .sto_vld (sto_vld),
    .sto_rdy (sto_rdy),
    .sto_lst (sto_lst)
  );

endmodule

//--- hdl/la_trigger.sv
////////////////////////////////////////
// edge trigger on the decimated stream
// matches current and previous sample
////////////////////////////////////////

`timescale 1ns/1ps

`include "la_defs.svh"

module la_trigger (
  input  logic                  bus,
  input  logic                  rst_n,
  input  logic                  ctl_rst,
  // match configuration
  input  la_stream_pkg::dat_t   cfg_msk_cur,
  input  la_stream_pkg::dat_t   cfg_msk_old,
  input  la_stream_pkg::dat_t   cfg_val_cur,
  input  la_stream_pkg::dat_t   cfg_val_old,
  // monitored stream
  input  la_stream_pkg::dat_t   str_dat,
  input  logic                  str_vld,
  input  logic                  str_rdy,
  output logic                  trg_flag   // combinational match
);

  la_stream_pkg::dat_t old_dat;  // last transferred sample
  logic                old_vld;  // old_dat holds a real sample
  logic                cur_hit;
  logic                old_hit;

  ////////////////////////////////////////
  // previous sample
  ////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n || ctl_rst) begin
      old_vld <= 1'b0;
    end else if (str_vld && str_rdy) begin
      old_vld <= 1'b1;
    end
  end

  always_ff @(posedge bus) begin
    if (str_vld && str_rdy) old_dat <= str_dat;
  end

  // both halves of the edge must match
  assign cur_hit  = (str_dat & cfg_msk_cur) == cfg_val_cur;
  assign old_hit  = (old_dat & cfg_msk_old) == cfg_val_old;
  assign trg_flag = old_vld & cur_hit & old_hit;

endmodule

//--- run.sh
#!/bin/sh
# build the logic analyzer testbench with Verilator, run it, check the log

rm -rf obj_dir sim.log

verilator --binary --timing -f verilog.f --top-module la_tb -o la_sim \
  || { echo "verilator build failed"; exit 1; }

./obj_dir/la_sim > sim.log 2>&1 || echo "simulator exited with an error"

cat sim.log

grep -qx "test passed" sim.log && echo "simulation ok" \
  || { echo "simulation failed"; exit 1; }

//--- verif/la_tb.sv
////////////////////////////////////////
// logic analyzer testbench
// register map, decimation, edge / sw / ext
// triggers, back-pressure and clear
////////////////////////////////////////

`timescale 1ns/1ps

module la_tb;

  localparam int ACK_TMO = 4;     // cycles past the expected ack
  localparam int RUN_TMO = 4000;  // cycles for a run or a drain
  localparam int POLLS   = 8;     // status reads per poll
  localparam int NROWS   = 8;

  localparam logic [1:0] SRC_EDGE = 2'd0;
  localparam logic [1:0] SRC_SW   = 2'd1;
  localparam logic [1:0] SRC_EXT  = 2'd2;

  // one test case
  typedef struct packed {
    logic [16:0] dec;
    logic [31:0] dly;
    logic [1:0]  sel;
    logic [7:0]  msk_cur;
    logic [7:0]  msk_old;
    logic [7:0]  val_cur;
    logic [7:0]  val_old;
    logic [1:0]  src;      // trigger source
    logic        bp;       // random sto_rdy
    logic [7:0]  last;     // sample carrying sto_lst
  } row_t;

  // dut ports
  logic        bus;
  logic        rst_n;
  logic [7:0]  sti_dat;
  logic        sti_vld;
  logic        sti_rdy;
  logic [7:0]  sto_dat;
  logic        sto_vld;
  logic        sto_rdy;
  logic        sto_lst;
  logic [3:0]  trg_ext;
  logic        trg_swo;
  logic        trg_out;
  logic [31:0] bus_addr;
  logic [31:0] bus_wdata;
  logic        bus_wen;
  logic        bus_ren;
  logic [31:0] bus_rdata;
  logic        bus_ack;
  logic        bus_err;

  int          seed;
  int          rnd;
  int          val_err;   // wrong values
  int          misc_err;  // timeouts and protocol
  // input stream driver
  logic [7:0]  ramp;      // next input sample
  logic        stream_on;
  logic        bp_on;
  logic        ramp_zero;
  logic        in_go;
  logic        en_s;
  logic        bp_s;
  logic        zero_s;
  logic        vld_s;
  // output monitor
  logic        have_prev;
  logic [7:0]  prev_dat;
  logic [7:0]  step8;     // cfg_dec+1
  int          out_cnt;
  int          trg_cnt;
  int          swo_cnt;   // sw strobe cycles seen
  logic        lst_seen;
  logic [7:0]  lst_dat;
  logic        forbid;    // no sto_vld allowed
  // main sequence
  row_t        rows [NROWS];
  row_t        rw;
  int          r;
  int          n;
  int          exp_cnt;
  logic        hit;

  la_top u_dut (
    .bus       (bus),
    .rst_n     (rst_n),
    .sti_dat   (sti_dat),
    .sti_vld   (sti_vld),
    .sti_rdy   (sti_rdy),
    .sto_dat   (sto_dat),
    .sto_vld   (sto_vld),
    .sto_rdy   (sto_rdy),
    .sto_lst   (sto_lst),
    .trg_ext   (trg_ext),
    .trg_swo   (trg_swo),
    .trg_out   (trg_out),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_wen   (bus_wen),
    .bus_ren   (bus_ren),
    .bus_rdata (bus_rdata),
    .bus_ack   (bus_ack),
    .bus_err   (bus_err)
  );

  always #2 bus = ~bus;  // 4 ns period

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
    val_err++;
  endtask

  task automatic report_problem(input string msg);
    $display("t=%0t error: %s", $time, msg);
    misc_err++;
  endtask

  // leaves the caller 1 ns after a rising edge
  task automatic idle_cycles(input int cnt);
    repeat (cnt) begin
      @(posedge bus);
      #1;
    end
  endtask

  ////////////////////////////////////////
  // register bus
  ////////////////////////////////////////

  task automatic bus_cycle(input logic wr, input logic [31:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    int w;
    bus_addr  = addr;
    bus_wdata = wdata;
    bus_wen   = wr;
    bus_ren   = ~wr;
    idle_cycles(1);
    bus_wen = 1'b0;
    bus_ren = 1'b0;
    w = 0;
    @(negedge bus);
    while (!bus_ack && w < ACK_TMO) begin
      @(negedge bus);
      w++;
    end
    if (!bus_ack) report_problem("timeout waiting for bus_ack");
    else if (w != 0) report_problem("bus_ack not one cycle after the access");
    if (bus_err !== 1'b0) report_mismatch("bus_err", 32'h0, 32'(bus_err));
    rdata = bus_rdata;
    idle_cycles(1);
    if (bus_ack) report_problem("bus_ack high for more than one cycle");
  endtask

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] dummy;
    bus_cycle(1'b1, addr, data, dummy);
  endtask

  task automatic reg_check(input logic [31:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] rd;
    bus_cycle(1'b0, addr, 32'h0, rd);
    if (rd !== exp) report_mismatch(name, exp, rd);
  endtask

  // reads REG_CTL until sts_trg shows up or the polls run out
  task automatic poll_trg(input int polls, output logic seen);
    logic [31:0] rd;
    int          p;
    seen = 1'b0;
    p    = 0;
    while (!seen && p < polls) begin
      bus_cycle(1'b0, la_regs_pkg::REG_CTL, 32'h0, rd);
      seen = rd[1];
      p++;
    end
  endtask

  task automatic pulse_ext(input logic [1:0] line);
    trg_ext = 4'b0001 << line;
    idle_cycles(1);
    trg_ext = 4'b0000;
  endtask

  // config, clear, start; stream is off here
  task automatic apply_config(input row_t c);
    reg_write(la_regs_pkg::REG_SEL, 32'(c.sel));
    reg_write(la_regs_pkg::REG_DLY, c.dly);
    reg_write(la_regs_pkg::REG_MSK_CUR, 32'(c.msk_cur));
    reg_write(la_regs_pkg::REG_MSK_OLD, 32'(c.msk_old));
    reg_write(la_regs_pkg::REG_VAL_CUR, 32'(c.val_cur));
    reg_write(la_regs_pkg::REG_VAL_OLD, 32'(c.val_old));
    reg_write(la_regs_pkg::REG_DEC, 32'(c.dec));
    reg_write(la_regs_pkg::REG_CTL, 32'h1);  // clear
    reg_write(la_regs_pkg::REG_CTL, 32'h4);  // start
  endtask

  task automatic monitor_reset(input logic [16:0] dec);
    step8     = 8'(dec + 17'd1);
    have_prev = 1'b0;
    lst_seen  = 1'b0;
    out_cnt   = 0;
    trg_cnt   = 0;
    swo_cnt   = 0;
  endtask

  // stop input, wait for the last pending sample, restart ramp at 0
  task automatic stream_drain();
    int d;
    stream_on = 1'b0;
    idle_cycles(2);
    d = 0;
    while (vld_s && d < RUN_TMO) begin
      idle_cycles(1);
      d++;
    end
    if (vld_s) report_problem("input stream did not drain");
    ramp_zero = 1'b1;
    idle_cycles(2);
    ramp_zero = 1'b0;
  endtask

  ////////////////////////////////////////
  // input ramp and output back-pressure
  ////////////////////////////////////////

  always begin
    @(negedge bus);
    in_go  = sti_vld && sti_rdy;  // transfer at next edge
    vld_s  = sti_vld;
    en_s   = stream_on;
    bp_s   = bp_on;
    zero_s = ramp_zero;
    @(posedge bus);
    #1;
    if (zero_s) ramp = 8'h00;
    else if (in_go) ramp = ramp + 8'h01;
    if (!sti_vld || in_go) begin  // hold until taken
      sti_dat = ramp;
      sti_vld = en_s;
    end
    rnd     = $random(seed);
    sto_rdy = bp_s ? rnd[0] : 1'b1;
  end

  // output checks, mid-cycle
  always @(negedge bus) begin
    if (trg_out) trg_cnt++;
    if (trg_swo) swo_cnt++;
    if (sto_vld && (forbid || lst_seen)) report_problem("sto_vld outside an acquisition");
    if (sto_vld && sto_rdy) begin
      if (!have_prev) begin
        if (sto_dat !== 8'h00) report_mismatch("sto_dat first", 32'h0, 32'(sto_dat));
      end else if (sto_dat !== prev_dat + step8) begin
        report_mismatch("sto_dat step", 32'(prev_dat + step8), 32'(sto_dat));
      end
      prev_dat  = sto_dat;
      have_prev = 1'b1;
      out_cnt++;
      if (sto_lst) begin
        lst_seen = 1'b1;
        lst_dat  = sto_dat;
      end
    end
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    bus       = 1'b0;
    rst_n     = 1'b0;
    sti_dat   = 8'h00;
    sti_vld   = 1'b0;
    sto_rdy   = 1'b1;
    trg_ext   = 4'b0000;
    bus_addr  = 32'h0;
    bus_wdata = 32'h0;
    bus_wen   = 1'b0;
    bus_ren   = 1'b0;
    seed      = 32'h9067_e062;
    val_err   = 0;
    misc_err  = 0;
    ramp      = 8'h00;
    stream_on = 1'b0;
    bp_on     = 1'b0;
    ramp_zero = 1'b0;
    forbid    = 1'b0;
    vld_s     = 1'b0;
    monitor_reset(17'd0);

    // dec, dly, sel, msk_cur, msk_old, val_cur, val_old, src, bp, last
    rows[0] = '{17'd0, 32'd5, 2'd0, 8'hff, 8'hff, 8'h10, 8'h0f, SRC_EDGE, 1'b0, 8'h15};
    rows[1] = '{17'd2, 32'd4, 2'd0, 8'hff, 8'h00, 8'h1e, 8'h00, SRC_EDGE, 1'b0, 8'h2a};
    rows[2] = '{17'd1, 32'd0, 2'd0, 8'h0f, 8'h0f, 8'h04, 8'h02, SRC_EDGE, 1'b1, 8'h04};
    rows[3] = '{17'd4, 32'd6, 2'd0, 8'hff, 8'h00, 8'h32, 8'h00, SRC_EDGE, 1'b1, 8'h50};
    rows[4] = '{17'd6, 32'd2, 2'd0, 8'h00, 8'hff, 8'h00, 8'h1c, SRC_EDGE, 1'b1, 8'h31};
    rows[5] = '{17'd1, 32'd7, 2'd0, 8'h00, 8'h00, 8'hff, 8'h00, SRC_SW,   1'b1, 8'h0e};
    rows[6] = '{17'd3, 32'd3, 2'd2, 8'h00, 8'h00, 8'hff, 8'h00, SRC_EXT,  1'b0, 8'h0c};
    rows[7] = '{17'd0, 32'd9, 2'd3, 8'h00, 8'h00, 8'hff, 8'h00, SRC_EXT,  1'b1, 8'h09};

    repeat (8) @(posedge bus);
    #1;
    rst_n = 1'b1;
    if (sto_vld || sto_lst || bus_ack || trg_out || trg_swo)
      report_problem("an output is not low after reset");

    // register map, readback masked to width
    reg_check(la_regs_pkg::REG_CTL, 32'h0, "ctl status after reset");
    reg_write(la_regs_pkg::REG_SEL, 32'hffff_fffe);
    reg_check(la_regs_pkg::REG_SEL, 32'h2, "cfg_sel");
    reg_write(la_regs_pkg::REG_DLY, 32'hdead_beef);
    reg_check(la_regs_pkg::REG_DLY, 32'hdead_beef, "cfg_dly");
    reg_write(la_regs_pkg::REG_MSK_CUR, 32'h1234_56a5);
    reg_check(la_regs_pkg::REG_MSK_CUR, 32'ha5, "cfg_msk_cur");
    reg_write(la_regs_pkg::REG_MSK_OLD, 32'h0000_ff5a);
    reg_check(la_regs_pkg::REG_MSK_OLD, 32'h5a, "cfg_msk_old");
    reg_write(la_regs_pkg::REG_VAL_CUR, 32'h8000_0133);
    reg_check(la_regs_pkg::REG_VAL_CUR, 32'h33, "cfg_val_cur");
    reg_write(la_regs_pkg::REG_VAL_OLD, 32'hffff_ffcc);
    reg_check(la_regs_pkg::REG_VAL_OLD, 32'hcc, "cfg_val_old");
    reg_write(la_regs_pkg::REG_DEC, 32'hffff_1234);
    reg_check(la_regs_pkg::REG_DEC, 32'h1_1234, "cfg_dec");
    reg_write(la_regs_pkg::REG_STS_DLY, 32'hffff_ffff);  // read only
    reg_check(la_regs_pkg::REG_STS_DLY, 32'h0, "sts_dly");
    reg_check(32'h04, 32'h0, "unmapped 04h");
    reg_check(32'h20, 32'h0, "unmapped 20h");
    reg_check(32'h24, 32'h0, "unmapped 24h");
    reg_check(32'h3c, 32'h0, "unmapped 3ch");

    for (r = 0; r < NROWS; r++) begin
      rw = rows[r];
      apply_config(rw);
      monitor_reset(rw.dec);
      bp_on = rw.bp;
      // sw / ext trigger taken before data, so sample 0 is the trigger sample
      if (rw.src == SRC_SW) begin
        reg_write(la_regs_pkg::REG_CTL, 32'h2);
        poll_trg(POLLS, hit);
        if (!hit) report_problem("software trigger did not set sts_trg");
      end else if (rw.src == SRC_EXT) begin
        pulse_ext(rw.sel + 2'd1);  // wrong line first
        poll_trg(POLLS, hit);
        if (hit) report_problem("unselected external line caused a trigger");
        pulse_ext(rw.sel);
        poll_trg(POLLS, hit);
        if (!hit) report_problem("external trigger did not set sts_trg");
      end
      stream_on = 1'b1;
      n = 0;
      while (!lst_seen && n < RUN_TMO) begin
        idle_cycles(1);
        n++;
      end
      if (!lst_seen) begin
        report_problem("timeout waiting for sto_lst");
      end else begin
        if (lst_dat !== rw.last) report_mismatch("sto_dat at sto_lst", 32'(rw.last), 32'(lst_dat));
        exp_cnt = int'(rw.last) / (int'(rw.dec) + 1) + 1;  // ramp starts at 0, no wrap
        if (out_cnt != exp_cnt) report_mismatch("output count", 32'(exp_cnt), 32'(out_cnt));
      end
      // masks of sw / ext rows can never match
      if (rw.src == SRC_EDGE) begin
        if (trg_cnt == 0) report_problem("trg_out never pulsed");
      end else if (trg_cnt != 0) begin
        report_problem("trg_out pulsed without an edge match");
      end
      // one strobe per sw trigger write
      if (rw.src == SRC_SW) begin
        if (swo_cnt != 1) report_mismatch("trg_swo pulses", 32'd1, 32'(swo_cnt));
      end else if (swo_cnt != 0) begin
        report_mismatch("trg_swo pulses", 32'd0, 32'(swo_cnt));
      end
      stream_drain();
      reg_check(la_regs_pkg::REG_CTL, 32'h2, "ctl status after run");
      reg_check(la_regs_pkg::REG_STS_DLY, 32'h0, "sts_dly after run");
    end

    // clear in the middle of a triggered run
    rw = '{17'd1, 32'd1000, 2'd0, 8'h00, 8'h00, 8'hff, 8'h00, SRC_SW, 1'b1, 8'h00};
    apply_config(rw);
    monitor_reset(rw.dec);
    bp_on     = 1'b1;
    reg_write(la_regs_pkg::REG_CTL, 32'h2);  // sw trigger, long post-trigger count
    stream_on = 1'b1;
    n = 0;
    while (out_cnt < 6 && n < RUN_TMO) begin
      idle_cycles(1);
      n++;
    end
    if (out_cnt < 6) report_problem("timeout waiting for output before clear");
    reg_check(la_regs_pkg::REG_CTL, 32'h6, "ctl status while running");
    reg_write(la_regs_pkg::REG_CTL, 32'h1);
    forbid = 1'b1;
    reg_check(la_regs_pkg::REG_CTL, 32'h0, "ctl status after clear");
    reg_check(la_regs_pkg::REG_STS_DLY, 32'h0, "sts_dly after clear");
    idle_cycles(40);  // input keeps flowing, output must stay quiet
    forbid = 1'b0;
    stream_drain();

    $display("errors: %0d value mismatches, %0d other failures", val_err, misc_err);
    if (val_err == 0 && misc_err == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+hdl
hdl/la_stream_pkg.sv
hdl/la_regs_pkg.sv
hdl/la_decimator.sv
hdl/la_trigger.sv
hdl/la_fifo.sv
hdl/la_acquire.sv
hdl/la_top.sv
verif/la_tb.sv
